// File: Makefile
VERILATOR  ?= verilator
TOP        := cpu_tb
FILELIST   := project.f
FLAGS      := --binary --timing --assert --timescale 1ns/1ps -j 0
LINT_FLAGS := --lint-only --timing --timescale 1ns/1ps
OBJ_DIR    := obj_dir
LOG        := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "Simulation PASSED" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: hdl/cpu_defines.svh
/* Widths, memory depth and the MIPS encodings kept by the core.
   Only the word-aligned subset is encoded here: no branch, jump, byte or halfword codes */
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

`define CPU_XLEN        32
`define CPU_REG_AW      5
`define CPU_DMEM_WORDS  64      // Word address bits above bit 1
`define CPU_PC_RESET    32'h0000_0000

////////////////////
// Opcodes
`define CPU_OP_RTYPE    6'h00
`define CPU_OP_ADDIU    6'h09
`define CPU_OP_ORI      6'h0d
`define CPU_OP_LW       6'h23
`define CPU_OP_SW       6'h2b

////////////////////
// R-type function codes
`define CPU_FN_ADDU     6'h21
`define CPU_FN_SUBU     6'h23
`define CPU_FN_AND      6'h24
`define CPU_FN_OR       6'h25
`define CPU_FN_SLT      6'h2a

`endif

// File: hdl/cpu_pkg.sv
/* Types shared by the pipeline stages */
package cpu_pkg;

    // ALU operations carried from decode to execute
    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,     // Wrapping, also used for address calc
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_SLT = 3'd4      // Signed compare
    } alu_op_t;

    // Writeback value source
    typedef enum logic {
        WB_ALU  = 1'b0,
        WB_LOAD = 1'b1
    } wb_src_t;

endpackage

// File: hdl/cpu_top.sv
/* Five-stage integer core with external instruction memory.
   Retired register writes leave on wb_*, one per cycle at most */
`timescale 1ns/1ps
`include "cpu_defines.svh"

module cpu_top (
    input  logic                   clk,
    input  logic                   reset_i,
    input  logic [`CPU_XLEN-1:0]   imem_data_i,
    output logic [`CPU_XLEN-1:0]   imem_addr_o,
    output logic                   wb_wena_o,
    output logic [`CPU_REG_AW-1:0] wb_addr_o,
    output logic [`CPU_XLEN-1:0]   wb_data_o
);

    logic                   stall;

    // Fetch to decode
    logic [`CPU_XLEN-1:0]   id_instr;
    logic                   id_valid;

    // Decode to execute
    logic                   ex_valid;
    cpu_pkg::alu_op_t       ex_alu_op;
    logic [`CPU_XLEN-1:0]   ex_a, ex_b, ex_store_data;
    logic [`CPU_REG_AW-1:0] ex_dest;
    logic                   ex_wena, ex_load, ex_store;

    // Execute to memory
    logic [`CPU_XLEN-1:0]   mem_result, mem_store_data;
    logic [`CPU_REG_AW-1:0] mem_dest;
    logic                   mem_wena, mem_load, mem_store;

    // Forwarding paths
    logic [`CPU_XLEN-1:0]   ex_fwd_result, mem_fwd_data;
    logic [`CPU_REG_AW-1:0] ex_fwd_dest, mem_fwd_dest;
    logic                   ex_fwd_wena, ex_fwd_load, mem_fwd_wena;

    fetch_stage fetch0 (
        .clk(clk), .reset_i(reset_i), .stall_i(stall),
        .imem_data_i(imem_data_i), .imem_addr_o(imem_addr_o),
        .id_instr_o(id_instr), .id_valid_o(id_valid)
    );

    decode_stage decode0 (
        .clk(clk), .reset_i(reset_i),
        .id_instr_i(id_instr), .id_valid_i(id_valid),
        .ex_fwd_result_i(ex_fwd_result), .ex_fwd_dest_i(ex_fwd_dest),
        .ex_fwd_wena_i(ex_fwd_wena), .ex_fwd_load_i(ex_fwd_load),
        .mem_fwd_data_i(mem_fwd_data), .mem_fwd_dest_i(mem_fwd_dest),
        .mem_fwd_wena_i(mem_fwd_wena),
        .wb_wena_i(wb_wena_o), .wb_addr_i(wb_addr_o), .wb_data_i(wb_data_o),
        .stall_o(stall),
        .ex_valid_o(ex_valid), .ex_alu_op_o(ex_alu_op),
        .ex_a_o(ex_a), .ex_b_o(ex_b), .ex_store_data_o(ex_store_data),
        .ex_dest_o(ex_dest), .ex_wena_o(ex_wena),
        .ex_load_o(ex_load), .ex_store_o(ex_store)
    );

    execute_stage execute0 (
        .clk(clk), .reset_i(reset_i),
        .ex_valid_i(ex_valid), .ex_alu_op_i(ex_alu_op),
        .ex_a_i(ex_a), .ex_b_i(ex_b), .ex_store_data_i(ex_store_data),
        .ex_dest_i(ex_dest), .ex_wena_i(ex_wena),
        .ex_load_i(ex_load), .ex_store_i(ex_store),
        .ex_fwd_result_o(ex_fwd_result), .ex_fwd_dest_o(ex_fwd_dest),
        .ex_fwd_wena_o(ex_fwd_wena), .ex_fwd_load_o(ex_fwd_load),
        .mem_result_o(mem_result), .mem_store_data_o(mem_store_data),
        .mem_dest_o(mem_dest), .mem_wena_o(mem_wena),
        .mem_load_o(mem_load), .mem_store_o(mem_store)
    );

    memory_stage memory0 (
        .clk(clk), .reset_i(reset_i),
        .mem_result_i(mem_result), .mem_store_data_i(mem_store_data),
        .mem_dest_i(mem_dest), .mem_wena_i(mem_wena),
        .mem_load_i(mem_load), .mem_store_i(mem_store),
        .mem_fwd_data_o(mem_fwd_data), .mem_fwd_dest_o(mem_fwd_dest),
        .mem_fwd_wena_o(mem_fwd_wena),
        .wb_wena_o(wb_wena_o), .wb_addr_o(wb_addr_o), .wb_data_o(wb_data_o)
    );

endmodule

// File: hdl/decode_stage.sv
/* Register file, decode, operand forwarding and load-use stall.
   Unsupported encodings, all-zero words included, leave as bubbles */
`timescale 1ns/1ps
`include "cpu_defines.svh"

module decode_stage (
    input  logic                   clk,
    input  logic                   reset_i,
    input  logic [`CPU_XLEN-1:0]   id_instr_i,
    input  logic                   id_valid_i,
    input  logic [`CPU_XLEN-1:0]   ex_fwd_result_i,
    input  logic [`CPU_REG_AW-1:0] ex_fwd_dest_i,
    input  logic                   ex_fwd_wena_i,
    input  logic                   ex_fwd_load_i,
    input  logic [`CPU_XLEN-1:0]   mem_fwd_data_i,
    input  logic [`CPU_REG_AW-1:0] mem_fwd_dest_i,
    input  logic                   mem_fwd_wena_i,
    input  logic                   wb_wena_i,
    input  logic [`CPU_REG_AW-1:0] wb_addr_i,
    input  logic [`CPU_XLEN-1:0]   wb_data_i,
    output logic                   stall_o,
    output logic                   ex_valid_o,
    output cpu_pkg::alu_op_t       ex_alu_op_o,
    output logic [`CPU_XLEN-1:0]   ex_a_o,
    output logic [`CPU_XLEN-1:0]   ex_b_o,
    output logic [`CPU_XLEN-1:0]   ex_store_data_o,
    output logic [`CPU_REG_AW-1:0] ex_dest_o,
    output logic                   ex_wena_o,
    output logic                   ex_load_o,
    output logic                   ex_store_o
);

    logic [`CPU_XLEN-1:0]   regs [0:(1 << `CPU_REG_AW)-1];
    logic [5:0]             opcode;
    logic [5:0]             funct;
    logic [`CPU_REG_AW-1:0] rs, rt, rd;
    logic [15:0]            imm;
    logic [`CPU_XLEN-1:0]   imm_ext;
    logic [`CPU_REG_AW-1:0] src [2];
    logic [`CPU_XLEN-1:0]   opnd [2];
    cpu_pkg::alu_op_t       alu_op;
    logic                   legal, use_imm, zext_imm, use_rt;
    logic                   wena, load, store, issue;
    logic [`CPU_REG_AW-1:0] dest;

    assign opcode = id_instr_i[31:26];
    assign rs     = id_instr_i[25:21];
    assign rt     = id_instr_i[20:16];
    assign rd     = id_instr_i[15:11];
    assign imm    = id_instr_i[15:0];
    assign funct  = id_instr_i[5:0];
    assign imm_ext = zext_imm ? {{(`CPU_XLEN-16){1'b0}}, imm} : {{(`CPU_XLEN-16){imm[15]}}, imm};

    ////////////////////
    // Instruction decode
    always_comb begin
        legal    = 1'b1;
        alu_op   = cpu_pkg::ALU_ADD;
        use_imm  = 1'b1;
        zext_imm = 1'b0;
        use_rt   = 1'b0;
        dest     = rt;
        wena     = 1'b0;
        load     = 1'b0;
        store    = 1'b0;
        case (opcode)
            `CPU_OP_RTYPE: begin
                use_imm = 1'b0;
                use_rt  = 1'b1;
                dest    = rd;
                wena    = 1'b1;
                case (funct)
                    `CPU_FN_ADDU: alu_op = cpu_pkg::ALU_ADD;
                    `CPU_FN_SUBU: alu_op = cpu_pkg::ALU_SUB;
                    `CPU_FN_AND:  alu_op = cpu_pkg::ALU_AND;
                    `CPU_FN_OR:   alu_op = cpu_pkg::ALU_OR;
                    `CPU_FN_SLT:  alu_op = cpu_pkg::ALU_SLT;
                    default:      legal  = 1'b0;
                endcase
            end
            `CPU_OP_ADDIU: wena = 1'b1;
            `CPU_OP_ORI: begin
                alu_op   = cpu_pkg::ALU_OR;
                zext_imm = 1'b1;
                wena     = 1'b1;
            end
            `CPU_OP_LW: begin
                wena = 1'b1;
                load = 1'b1;
            end
            `CPU_OP_SW: begin
                use_rt = 1'b1;      // Store data
                store  = 1'b1;
            end
            default: legal = 1'b0;
        endcase
    end

    ////////////////////
    // Operands: execute, then memory, then register file (write-first)
    assign src[0] = rs;
    assign src[1] = rt;

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            if (src[i] == '0)
                opnd[i] = '0;
            else if (ex_fwd_wena_i && ex_fwd_dest_i == src[i])
                opnd[i] = ex_fwd_result_i;
            else if (mem_fwd_wena_i && mem_fwd_dest_i == src[i])
                opnd[i] = mem_fwd_data_i;
            else if (wb_wena_i && wb_addr_i == src[i])
                opnd[i] = wb_data_i;
            else
                opnd[i] = regs[src[i]];
        end
    end

    // Load in execute feeding this instruction, wait one cycle
    assign stall_o = id_valid_i && legal && ex_fwd_load_i && ex_fwd_wena_i &&
                     (ex_fwd_dest_i != '0) &&
                     ((ex_fwd_dest_i == rs) || (use_rt && ex_fwd_dest_i == rt));
    assign issue = id_valid_i && legal && !stall_o;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < (1 << `CPU_REG_AW); i++) begin
                regs[i] <= '0;
            end
        end else if (wb_wena_i && wb_addr_i != '0) begin
            regs[wb_addr_i] <= wb_data_i;
        end
    end

    ////////////////////
    // Decode/execute register
    always_ff @(posedge clk) begin
        if (reset_i) begin
            ex_valid_o <= 1'b0;
            ex_wena_o  <= 1'b0;
            ex_load_o  <= 1'b0;
            ex_store_o <= 1'b0;
        end else begin
            ex_valid_o <= issue;                            // Bubble on stall
            ex_wena_o  <= issue && wena && (dest != '0);    // r0 never written
            ex_load_o  <= issue && load;
            ex_store_o <= issue && store;
        end
    end

    always_ff @(posedge clk) begin
        ex_alu_op_o     <= alu_op;
        ex_a_o          <= opnd[0];
        ex_b_o          <= use_imm ? imm_ext : opnd[1];
        ex_store_data_o <= opnd[1];
        ex_dest_o       <= dest;
    end

endmodule

// File: hdl/execute_stage.sv
/* ALU and execute/memory register. Loads and stores use the add
   result as the byte address */
`timescale 1ns/1ps
`include "cpu_defines.svh"

module execute_stage (
    input  logic                   clk,
    input  logic                   reset_i,
    input  logic                   ex_valid_i,
    input  cpu_pkg::alu_op_t       ex_alu_op_i,
    input  logic [`CPU_XLEN-1:0]   ex_a_i,
    input  logic [`CPU_XLEN-1:0]   ex_b_i,
    input  logic [`CPU_XLEN-1:0]   ex_store_data_i,
    input  logic [`CPU_REG_AW-1:0] ex_dest_i,
    input  logic                   ex_wena_i,
    input  logic                   ex_load_i,
    input  logic                   ex_store_i,
    output logic [`CPU_XLEN-1:0]   ex_fwd_result_o,
    output logic [`CPU_REG_AW-1:0] ex_fwd_dest_o,
    output logic                   ex_fwd_wena_o,
    output logic                   ex_fwd_load_o,
    output logic [`CPU_XLEN-1:0]   mem_result_o,
    output logic [`CPU_XLEN-1:0]   mem_store_data_o,
    output logic [`CPU_REG_AW-1:0] mem_dest_o,
    output logic                   mem_wena_o,
    output logic                   mem_load_o,
    output logic                   mem_store_o
);

    logic [`CPU_XLEN-1:0] result;

    always_comb begin
        case (ex_alu_op_i)
            cpu_pkg::ALU_SUB: result = ex_a_i - ex_b_i;
            cpu_pkg::ALU_AND: result = ex_a_i & ex_b_i;
            cpu_pkg::ALU_OR:  result = ex_a_i | ex_b_i;
            cpu_pkg::ALU_SLT: result = {{(`CPU_XLEN-1){1'b0}}, $signed(ex_a_i) < $signed(ex_b_i)};
            default:          result = ex_a_i + ex_b_i;
        endcase
    end

    // Back to decode for forwarding and the load-use check
    assign ex_fwd_result_o = result;
    assign ex_fwd_dest_o   = ex_dest_i;
    assign ex_fwd_wena_o   = ex_valid_i && ex_wena_i;
    assign ex_fwd_load_o   = ex_valid_i && ex_load_i;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            mem_wena_o  <= 1'b0;
            mem_load_o  <= 1'b0;
            mem_store_o <= 1'b0;
        end else begin
            mem_wena_o  <= ex_valid_i && ex_wena_i;
            mem_load_o  <= ex_valid_i && ex_load_i;
            mem_store_o <= ex_valid_i && ex_store_i;
        end
    end

    always_ff @(posedge clk) begin
        mem_result_o     <= result;
        mem_store_data_o <= ex_store_data_i;
        mem_dest_o       <= ex_dest_i;
    end

endmodule

// File: hdl/fetch_stage.sv
/* PC and fetch/decode register, both hold while stall_i is high.
   Instruction memory is outside; imem_data_i must follow imem_addr_o in the same cycle */
`timescale 1ns/1ps
`include "cpu_defines.svh"

module fetch_stage (
    input  logic                 clk,
    input  logic                 reset_i,
    input  logic                 stall_i,
    input  logic [`CPU_XLEN-1:0] imem_data_i,
    output logic [`CPU_XLEN-1:0] imem_addr_o,
    output logic [`CPU_XLEN-1:0] id_instr_o,
    output logic                 id_valid_o
);

    logic [`CPU_XLEN-1:0] pc;

    assign imem_addr_o = pc;

    // No branches, so the PC only advances or holds
    always_ff @(posedge clk) begin
        if (reset_i) begin
            pc         <= `CPU_PC_RESET;
            id_valid_o <= 1'b0;
        end else if (!stall_i) begin
            pc         <= pc + `CPU_XLEN'd4;
            id_valid_o <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            id_instr_o <= imem_data_i;
        end
    end

endmodule

// File: hdl/memory_stage.sv
/* Data memory of CPU_DMEM_WORDS words, word access only; address bits above
   the word index are ignored. Read is asynchronous, write on the clock edge */
`timescale 1ns/1ps
`include "cpu_defines.svh"

module memory_stage (
    input  logic                   clk,
    input  logic                   reset_i,
    input  logic [`CPU_XLEN-1:0]   mem_result_i,
    input  logic [`CPU_XLEN-1:0]   mem_store_data_i,
    input  logic [`CPU_REG_AW-1:0] mem_dest_i,
    input  logic                   mem_wena_i,
    input  logic                   mem_load_i,
    input  logic                   mem_store_i,
    output logic [`CPU_XLEN-1:0]   mem_fwd_data_o,
    output logic [`CPU_REG_AW-1:0] mem_fwd_dest_o,
    output logic                   mem_fwd_wena_o,
    output logic                   wb_wena_o,
    output logic [`CPU_REG_AW-1:0] wb_addr_o,
    output logic [`CPU_XLEN-1:0]   wb_data_o
);

    localparam int DMEM_AW = $clog2(`CPU_DMEM_WORDS);

    logic [`CPU_XLEN-1:0] dmem [0:`CPU_DMEM_WORDS-1];
    logic [DMEM_AW-1:0]   word_addr;
    logic [`CPU_XLEN-1:0] load_data;
    logic [`CPU_XLEN-1:0] wb_value;
    cpu_pkg::wb_src_t     wb_src;

    assign word_addr = mem_result_i[DMEM_AW+1:2];
    assign load_data = dmem[word_addr];

    always_ff @(posedge clk) begin
        if (mem_store_i) begin
            dmem[word_addr] <= mem_store_data_i;
        end
    end

    assign wb_src   = mem_load_i ? cpu_pkg::WB_LOAD : cpu_pkg::WB_ALU;
    assign wb_value = (wb_src == cpu_pkg::WB_LOAD) ? load_data : mem_result_i;

    assign mem_fwd_data_o = wb_value;     // Load data is ready here
    assign mem_fwd_dest_o = mem_dest_i;
    assign mem_fwd_wena_o = mem_wena_i;

    ////////////////////
    // Memory/writeback register
    always_ff @(posedge clk) begin
        if (reset_i)
            wb_wena_o <= 1'b0;
        else
            wb_wena_o <= mem_wena_i;
    end

    always_ff @(posedge clk) begin
        wb_addr_o <= mem_dest_i;
        wb_data_o <= wb_value;
    end

endmodule

// File: project.f
+incdir+hdl
hdl/cpu_pkg.sv
hdl/fetch_stage.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/memory_stage.sv
hdl/cpu_top.sv
tests/cpu_assert.sv
tests/cpu_tb.sv

// File: tests/cpu_assert.sv
/* Protocol checks on the core top level, bound from the testbench.
   The PC may hold for one cycle at most, the load-use stall being the only hold */
`timescale 1ns/1ps
`include "cpu_defines.svh"

module cpu_assert (
    input logic                   clk,
    input logic                   reset_i,
    input logic [`CPU_XLEN-1:0]   imem_addr_i,
    input logic                   wb_wena_i,
    input logic [`CPU_REG_AW-1:0] wb_addr_i
);

    wb_quiet_after_reset: assert property (@(posedge clk) reset_i |=> !wb_wena_i)
        else $error("writeback strobe high in the cycle after reset");

    // r0 writes are dropped in decode
    wb_addr_nonzero: assert property (@(posedge clk) disable iff (reset_i)
        wb_wena_i |-> (wb_addr_i != '0))
        else $error("writeback strobe with register 0 as target");

    pc_step: assert property (@(posedge clk) disable iff (reset_i)
        !$past(reset_i) |-> (imem_addr_i == $past(imem_addr_i) + 32'd4) ||
                            (imem_addr_i == $past(imem_addr_i)))
        else $error("PC neither advanced by 4 nor held");

    pc_single_hold: assert property (@(posedge clk) disable iff (reset_i)
        (!$past(reset_i) && !$past(reset_i, 2) && ($past(imem_addr_i) == $past(imem_addr_i, 2)))
        |-> (imem_addr_i != $past(imem_addr_i)))
        else $error("PC held for two cycles in a row");

endmodule

// File: tests/cpu_tb.sv
/* Random program on registers 0 to 7 checked against an in-order ISA model.
   Loads and stores use r0 as base with offsets below 256 */
`timescale 1ns/1ps
`include "cpu_defines.svh"

module cpu_tb;

    localparam int PROG_LEN    = 200;
    localparam int CYCLE_LIMIT = 2 * PROG_LEN + 50;
    localparam int DRAIN       = 10;    // Watch for stray writebacks

    logic                   clk = 1'b0;
    logic                   reset_i;
    logic [`CPU_XLEN-1:0]   imem_data_i;
    logic [`CPU_XLEN-1:0]   imem_addr_o;
    logic                   wb_wena_o;
    logic [`CPU_REG_AW-1:0] wb_addr_o;
    logic [`CPU_XLEN-1:0]   wb_data_o;

    logic [31:0] prog [PROG_LEN];
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    int          cycle_count = 0;
    int          mismatch_count = 0;
    int          unexpected_count = 0;
    int          missing_count = 0;

    cpu_top dut0 (
        .clk(clk), .reset_i(reset_i),
        .imem_data_i(imem_data_i), .imem_addr_o(imem_addr_o),
        .wb_wena_o(wb_wena_o), .wb_addr_o(wb_addr_o), .wb_data_o(wb_data_o)
    );

    bind cpu_top cpu_assert assert0 (
        .clk(clk), .reset_i(reset_i), .imem_addr_i(imem_addr_o),
        .wb_wena_i(wb_wena_o), .wb_addr_i(wb_addr_o)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("error %0t: %s is %h, expected %h", $time, what, got, expected);
            mismatch_count++;
        end
    endtask

    // Zero past the end of the program
    function automatic logic [31:0] word_at(input logic [31:0] addr);
        int idx;
        idx = int'(addr >> 2);
        if (idx < PROG_LEN)
            return prog[idx];
        return '0;
    endfunction

    function automatic logic [5:0] pick_funct(input int unsigned sel);
        case (sel % 5)
            0:       return `CPU_FN_ADDU;
            1:       return `CPU_FN_SUBU;
            2:       return `CPU_FN_AND;
            3:       return `CPU_FN_OR;
            default: return `CPU_FN_SLT;
        endcase
    endfunction

    ////////////////////
    // Program generation
    task automatic build_program();
        int unsigned kind;
        logic [4:0]  rs, rt, rd, load_dest;
        logic [15:0] imm;
        logic [5:0]  slot;
        logic        stored [64];
        logic        after_load;
        int          n_stored;
        n_stored   = 0;
        after_load = 1'b0;
        load_dest  = '0;
        for (int i = 0; i < 64; i++)
            stored[i] = 1'b0;
        for (int i = 0; i < PROG_LEN; i++) begin
            kind = $urandom % 10;
            rs   = 5'($urandom % 8);
            rt   = 5'($urandom % 8);
            rd   = 5'($urandom % 8);
            imm  = 16'($urandom);
            slot = 6'($urandom);
            if (after_load && ($urandom % 2) == 0)
                rs = load_dest;                 // Consumer right behind a load
            after_load = 1'b0;
            if (kind < 3) begin
                prog[i] = {`CPU_OP_RTYPE, rs, rt, rd, 5'd0, pick_funct($urandom)};
            end else if (kind < 5) begin
                prog[i] = {`CPU_OP_ADDIU, rs, rt, imm};
            end else if (kind == 5) begin
                prog[i] = {`CPU_OP_ORI, rs, rt, imm};
            end else if (kind < 8 && n_stored != 0) begin
                while (!stored[slot])
                    slot = slot + 6'd1;
                prog[i]    = {`CPU_OP_LW, 5'd0, rt, 8'd0, slot, 2'b00};
                after_load = 1'b1;
                load_dest  = rt;
            end else begin
                prog[i] = {`CPU_OP_SW, 5'd0, rt, 8'd0, slot, 2'b00};
                if (!stored[slot])
                    n_stored++;
                stored[slot] = 1'b1;
            end
        end
    endtask

    ////////////////////
    // ISA model queuing one expected writeback per nonzero register write
    task automatic run_model();
        logic [31:0] regs [32];
        logic [31:0] dmem [64];
        logic [31:0] instr, a, b, sext, zext, addr, val;
        logic [4:0]  dest;
        logic        writes;
        for (int i = 0; i < 32; i++)
            regs[i] = '0;
        for (int i = 0; i < 64; i++)
            dmem[i] = '0;
        for (int i = 0; i < PROG_LEN; i++) begin
            instr  = prog[i];
            a      = regs[instr[25:21]];
            b      = regs[instr[20:16]];
            sext   = {{16{instr[15]}}, instr[15:0]};
            zext   = {16'd0, instr[15:0]};
            addr   = a + sext;
            dest   = instr[20:16];
            writes = 1'b1;
            val    = '0;
            case (instr[31:26])
                `CPU_OP_RTYPE: begin
                    dest = instr[15:11];
                    case (instr[5:0])
                        `CPU_FN_ADDU: val = a + b;
                        `CPU_FN_SUBU: val = a - b;
                        `CPU_FN_AND:  val = a & b;
                        `CPU_FN_OR:   val = a | b;
                        `CPU_FN_SLT:  val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default:      writes = 1'b0;
                    endcase
                end
                `CPU_OP_ADDIU: val = a + sext;
                `CPU_OP_ORI:   val = a | zext;
                `CPU_OP_LW:    val = dmem[addr[7:2]];
                `CPU_OP_SW: begin
                    dmem[addr[7:2]] = b;
                    writes = 1'b0;
                end
                default: writes = 1'b0;
            endcase
            if (writes && dest != '0) begin
                regs[dest] = val;
                exp_addr.push_back(32'(dest));
                exp_data.push_back(val);
            end
        end
    endtask

    // Instruction memory follows the PC
    always @(posedge clk) begin
        #1;
        imem_data_i = word_at(imem_addr_o);
    end

    always @(negedge clk) begin
        if (!reset_i && wb_wena_o) begin
            if (exp_addr.size() == 0) begin
                $display("Writeback to r%0d at %0t with no instruction left to retire",
                         wb_addr_o, $time);
                unexpected_count++;
            end else begin
                check_value("writeback register", 32'(wb_addr_o), exp_addr.pop_front());
                check_value("writeback data", wb_data_o, exp_data.pop_front());
            end
        end
    end

    initial begin
        $timeformat(-9, 0, " ns", 0);
        void'($urandom(32'h3d4a43f0));
        reset_i     = 1'b1;
        imem_data_i = '0;
        build_program();
        run_model();
        imem_data_i = word_at(`CPU_PC_RESET);
        repeat (10) @(posedge clk);
        #1;
        reset_i = 1'b0;
        check_value("PC after reset", imem_addr_o, `CPU_PC_RESET);
        check_value("writeback strobe after reset", 32'(wb_wena_o), 32'd0);

        while (exp_addr.size() != 0 && cycle_count < CYCLE_LIMIT)
            @(posedge clk);
        if (exp_addr.size() != 0) begin
            missing_count = exp_addr.size();
            $display("Run stopped at the %0d-cycle limit with %0d writebacks never seen",
                     CYCLE_LIMIT, missing_count);
        end else begin
            repeat (DRAIN) @(posedge clk);
        end

        $display("Errors: %0d mismatches, %0d unexpected writebacks, %0d missing writebacks",
                 mismatch_count, unexpected_count, missing_count);
        if (mismatch_count + unexpected_count + missing_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule
